//--- src/proc_bus_consts.svh
`ifndef PROC_BUS_CONSTS_SVH
`define PROC_BUS_CONSTS_SVH

`define MEM_WORDS      256             // SRAM depth in words
`define MEM_WAIT       2               // Cycles from first strobe to ack

// SRAM window, 1 KiB at zero
`define SRAM_BASE      32'h0000_0000
`define SRAM_SPAN      32'h0000_0400

// I/O window
`define IO_BASE        32'h1000_0000
`define IO_SPAN        32'h0000_0100
`define IO_GPIO_OFS    32'h0000_0000
`define IO_SCRATCH_OFS 32'h0000_0004

`define UNMAPPED_DATA  32'hDEAD_BEEF   // Read value outside both windows

`endif

//--- src/proc_bus_pkg.sv
`default_nettype none

package proc_bus_pkg;

    typedef logic [31:0] word_t;    // Bus data word
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [3:0]  strb_t;    // One enable per byte lane
    typedef logic [7:0]  gpio_t;

    // Slave picked by the address decoder
    typedef enum logic [1:0] {
        REGION_SRAM = 2'd0,
        REGION_IO   = 2'd1,
        REGION_NONE = 2'd2
    } region_e;

endpackage

`default_nettype wire

//--- src/core_bus_master.sv
`timescale 1ns/100ps
`default_nettype none

module core_bus_master (
    input  wire                        sys_clk_i,
    input  wire                        rst_i,
    // Core memory port
    input  wire                        mem_read_i,
    input  wire                        mem_write_i,
    input  wire proc_bus_pkg::addr_t   address_i,
    input  wire proc_bus_pkg::word_t   write_data_i,
    input  wire proc_bus_pkg::strb_t   wstrb_i,
    output proc_bus_pkg::word_t        read_data_o,
    output logic                       mem_response_o,
    // Wishbone master
    output logic                       wb_cyc_o,
    output logic                       wb_stb_o,
    output logic                       wb_we_o,
    output proc_bus_pkg::addr_t        wb_adr_o,
    output proc_bus_pkg::word_t        wb_dat_o,
    output proc_bus_pkg::strb_t        wb_sel_o,
    input  wire proc_bus_pkg::word_t   wb_dat_i,
    input  wire                        wb_ack_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESP
    } state_e;

    state_e state_q;
    logic   req;

    assign req = mem_read_i | mem_write_i;

    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            wb_we_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req) begin
                        state_q <= ST_BUS;
                        wb_we_o <= mem_write_i;   // Write wins if both levels are up
                    end
                end
                ST_BUS: begin
                    if (wb_ack_i) begin
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    state_q <= ST_IDLE;   // Held level not sampled in this cycle
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Request fields latched once and held until ack
    always_ff @(posedge sys_clk_i) begin
        if (state_q == ST_IDLE && req) begin
            wb_adr_o <= address_i;
            wb_dat_o <= write_data_i;
            wb_sel_o <= mem_write_i ? wstrb_i : '1;
        end
        if (state_q == ST_BUS && wb_ack_i) begin
            read_data_o <= wb_dat_i;
        end
    end

    assign wb_cyc_o       = (state_q == ST_BUS);
    assign wb_stb_o       = (state_q == ST_BUS);
    assign mem_response_o = (state_q == ST_RESP);

    // Core keeps its request steady until the response
    a_req_stable: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        wb_cyc_o |-> $stable(mem_read_i) && $stable(mem_write_i) && $stable(address_i)
            && $stable(write_data_i) && $stable(wstrb_i));

endmodule

`default_nettype wire

//--- src/wb_addr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "proc_bus_consts.svh"

module wb_addr_decoder (
    input  wire                        sys_clk_i,
    input  wire                        rst_i,
    // From the master
    input  wire                        m_cyc_i,
    input  wire                        m_stb_i,
    input  wire                        m_we_i,
    input  wire proc_bus_pkg::addr_t   m_adr_i,
    output proc_bus_pkg::word_t        m_dat_o,
    output logic                       m_ack_o,
    // SRAM slave
    output logic                       sram_stb_o,
    input  wire proc_bus_pkg::word_t   sram_dat_i,
    input  wire                        sram_ack_i,
    // I/O slave
    output logic                       io_stb_o,
    input  wire proc_bus_pkg::word_t   io_dat_i,
    input  wire                        io_ack_i
);

    proc_bus_pkg::region_e region;
    logic                  req;
    logic                  none_ack_q;

    assign req = m_cyc_i & m_stb_i;

    // Offsets wrap below the base so one compare covers a window
    always_comb begin
        if ((m_adr_i - `SRAM_BASE) < `SRAM_SPAN) begin
            region = proc_bus_pkg::REGION_SRAM;
        end else if ((m_adr_i - `IO_BASE) < `IO_SPAN) begin
            region = proc_bus_pkg::REGION_IO;
        end else begin
            region = proc_bus_pkg::REGION_NONE;
        end
    end

    assign sram_stb_o = req && (region == proc_bus_pkg::REGION_SRAM);
    assign io_stb_o   = req && (region == proc_bus_pkg::REGION_IO);

    // Unmapped cycles acked here and their writes dropped
    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= req && (region == proc_bus_pkg::REGION_NONE) && !none_ack_q;
        end
    end

    always_comb begin
        case (region)
            proc_bus_pkg::REGION_SRAM: begin
                m_ack_o = sram_ack_i;
                m_dat_o = sram_dat_i;
            end
            proc_bus_pkg::REGION_IO: begin
                m_ack_o = io_ack_i;
                m_dat_o = io_dat_i;
            end
            default: begin
                m_ack_o = none_ack_q;
                m_dat_o = m_we_i ? '0 : `UNMAPPED_DATA;   // Pattern on reads only
            end
        endcase
    end

    // A slave answers only while its own strobe is up
    a_ack_strobed: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        (sram_ack_i |-> sram_stb_o) and (io_ack_i |-> io_stb_o));

endmodule

`default_nettype wire

//--- src/wb_sram.sv
`timescale 1ns/100ps
`default_nettype none

`include "proc_bus_consts.svh"

module wb_sram (
    input  wire                        sys_clk_i,
    input  wire                        rst_i,
    input  wire                        stb_i,
    input  wire                        we_i,
    input  wire proc_bus_pkg::addr_t   adr_i,
    input  wire proc_bus_pkg::word_t   dat_i,
    input  wire proc_bus_pkg::strb_t   sel_i,
    output proc_bus_pkg::word_t        dat_o,
    output logic                       ack_o
);

    localparam int IDX_W  = $clog2(`MEM_WORDS);
    localparam int WAIT_W = $clog2(`MEM_WAIT + 1);

    proc_bus_pkg::word_t mem [`MEM_WORDS];
    proc_bus_pkg::addr_t offset;
    logic [IDX_W-1:0]    word_idx;
    logic [WAIT_W-1:0]   wait_cnt_q;
    logic                last_wait;
    logic                fire;

    assign offset    = adr_i - `SRAM_BASE;
    assign word_idx  = offset[IDX_W+1:2];   // Byte address to word index
    assign last_wait = (wait_cnt_q == WAIT_W'(`MEM_WAIT - 1));
    assign fire      = stb_i && !ack_o && last_wait;

    // Wait states counted from the first strobed cycle
    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            ack_o      <= 1'b0;
            wait_cnt_q <= '0;
        end else if (stb_i && !ack_o) begin
            if (last_wait) begin
                ack_o      <= 1'b1;
                wait_cnt_q <= '0;
            end else begin
                wait_cnt_q <= wait_cnt_q + 1'b1;
            end
        end else begin
            ack_o      <= 1'b0;
            wait_cnt_q <= '0;   // Dropped strobe restarts the count
        end
    end

    // Access happens in the same edge that raises ack
    always_ff @(posedge sys_clk_i) begin
        if (fire) begin
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel_i[b]) begin
                        mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
            dat_o <= mem[word_idx];
        end
    end

    // Decoder must only strobe inside the window
    a_in_window: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        stb_i |-> (offset < `SRAM_SPAN));

endmodule

`default_nettype wire

//--- src/wb_io_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "proc_bus_consts.svh"

module wb_io_regs (
    input  wire                        sys_clk_i,
    input  wire                        rst_i,
    input  wire                        stb_i,
    input  wire                        we_i,
    input  wire proc_bus_pkg::addr_t   adr_i,
    input  wire proc_bus_pkg::word_t   dat_i,
    input  wire proc_bus_pkg::strb_t   sel_i,
    output proc_bus_pkg::word_t        dat_o,
    output logic                       ack_o,
    output proc_bus_pkg::gpio_t        gpio_o
);

    proc_bus_pkg::addr_t offset;
    proc_bus_pkg::word_t scratch_q;
    logic                fire;

    assign offset = adr_i - `IO_BASE;
    assign fire   = stb_i && !ack_o;

    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            ack_o     <= 1'b0;
            gpio_o    <= '0;
            scratch_q <= '0;
        end else begin
            ack_o <= fire;   // Single-cycle ack
            if (fire && we_i) begin
                if (offset == `IO_GPIO_OFS && sel_i[0]) begin
                    gpio_o <= dat_i[7:0];
                end
                if (offset == `IO_SCRATCH_OFS) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel_i[b]) begin
                            scratch_q[8*b +: 8] <= dat_i[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // Read mux, unused offsets give zero
    always_ff @(posedge sys_clk_i) begin
        if (fire) begin
            case (offset)
                `IO_GPIO_OFS:    dat_o <= {24'h0, gpio_o};
                `IO_SCRATCH_OFS: dat_o <= scratch_q;
                default:         dat_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/proc_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module proc_mem_top (
    input  wire                        sys_clk_i,
    input  wire                        rst_i,
    // Core memory port
    input  wire                        mem_read_i,
    input  wire                        mem_write_i,
    input  wire proc_bus_pkg::addr_t   address_i,
    input  wire proc_bus_pkg::word_t   write_data_i,
    input  wire proc_bus_pkg::strb_t   wstrb_i,
    output proc_bus_pkg::word_t        read_data_o,
    output logic                       mem_response_o,
    output proc_bus_pkg::gpio_t        gpio_o
);

    // Master side of the bus
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    proc_bus_pkg::addr_t wb_adr;
    proc_bus_pkg::word_t wb_dat_w;
    proc_bus_pkg::strb_t wb_sel;
    proc_bus_pkg::word_t wb_dat_r;
    logic                wb_ack;

    // Per-slave returns
    logic                sram_stb;
    logic                sram_ack;
    proc_bus_pkg::word_t sram_dat;
    logic                io_stb;
    logic                io_ack;
    proc_bus_pkg::word_t io_dat;

    core_bus_master u_master (
        .sys_clk_i      (sys_clk_i),
        .rst_i          (rst_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .address_i      (address_i),
        .write_data_i   (write_data_i),
        .wstrb_i        (wstrb_i),
        .read_data_o    (read_data_o),
        .mem_response_o (mem_response_o),
        .wb_cyc_o       (wb_cyc),
        .wb_stb_o       (wb_stb),
        .wb_we_o        (wb_we),
        .wb_adr_o       (wb_adr),
        .wb_dat_o       (wb_dat_w),
        .wb_sel_o       (wb_sel),
        .wb_dat_i       (wb_dat_r),
        .wb_ack_i       (wb_ack)
    );

    wb_addr_decoder u_decoder (
        .sys_clk_i  (sys_clk_i),
        .rst_i      (rst_i),
        .m_cyc_i    (wb_cyc),
        .m_stb_i    (wb_stb),
        .m_we_i     (wb_we),
        .m_adr_i    (wb_adr),
        .m_dat_o    (wb_dat_r),
        .m_ack_o    (wb_ack),
        .sram_stb_o (sram_stb),
        .sram_dat_i (sram_dat),
        .sram_ack_i (sram_ack),
        .io_stb_o   (io_stb),
        .io_dat_i   (io_dat),
        .io_ack_i   (io_ack)
    );

    wb_sram u_sram (
        .sys_clk_i (sys_clk_i),
        .rst_i     (rst_i),
        .stb_i     (sram_stb),
        .we_i      (wb_we),
        .adr_i     (wb_adr),
        .dat_i     (wb_dat_w),
        .sel_i     (wb_sel),
        .dat_o     (sram_dat),
        .ack_o     (sram_ack)
    );

    wb_io_regs u_io (
        .sys_clk_i (sys_clk_i),
        .rst_i     (rst_i),
        .stb_i     (io_stb),
        .we_i      (wb_we),
        .adr_i     (wb_adr),
        .dat_i     (wb_dat_w),
        .sel_i     (wb_sel),
        .dat_o     (io_dat),
        .ack_o     (io_ack),
        .gpio_o    (gpio_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,   // 10 ns clock
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

    // Released on an edge so the DUT sees whole reset cycles
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/tb_proc_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "proc_bus_consts.svh"

module tb_proc_mem_top;

    localparam int IDX_W         = $clog2(`MEM_WORDS);
    localparam int RESP_TIMEOUT  = 20;   // Cycles, far above the slowest slave
    localparam int RESET_TIMEOUT = 10;
    localparam int RANDOM_OPS    = 200;
    localparam int MAX_LINES     = 50;

    // Opcodes of the case file
    localparam logic [31:0] OP_END   = 32'd0;
    localparam logic [31:0] OP_WRITE = 32'd1;
    localparam logic [31:0] OP_READ  = 32'd2;
    localparam logic [31:0] OP_GPIO  = 32'd3;
    localparam logic [31:0] OP_MARK  = 32'd4;   // Closes a group of cases

    logic                sys_clk;
    logic                rst;
    logic                mem_read;
    logic                mem_write;
    proc_bus_pkg::addr_t address;
    proc_bus_pkg::word_t write_data;
    proc_bus_pkg::strb_t wstrb;
    proc_bus_pkg::word_t read_data;
    logic                mem_response;
    proc_bus_pkg::gpio_t gpio;

    proc_bus_pkg::word_t cases [256];
    proc_bus_pkg::word_t ref_mem [`MEM_WORDS];   // Reference SRAM contents
    logic                ref_valid [`MEM_WORDS];
    int                  errors;
    int                  tests;
    int                  failed_tests;

    tb_clock_gen clock_gen (
        .clk_o (sys_clk),
        .rst_o (rst)
    );

    proc_mem_top UUT (
        .sys_clk_i      (sys_clk),
        .rst_i          (rst),
        .mem_read_i     (mem_read),
        .mem_write_i    (mem_write),
        .address_i      (address),
        .write_data_i   (write_data),
        .wstrb_i        (wstrb),
        .read_data_o    (read_data),
        .mem_response_o (mem_response),
        .gpio_o         (gpio)
    );

    task automatic compare_word(input string name, input proc_bus_pkg::word_t expected,
                                input proc_bus_pkg::word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s expected %08h, got %08h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_gpio(input string name, input proc_bus_pkg::gpio_t expected,
                                input proc_bus_pkg::gpio_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s expected %02h, got %02h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: %0d errors", tests, name, errors - errors_before);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Address map as seen by the core
    function automatic proc_bus_pkg::region_e region_of(input proc_bus_pkg::addr_t addr);
        if ((addr - `SRAM_BASE) < `SRAM_SPAN) begin
            return proc_bus_pkg::REGION_SRAM;
        end
        if ((addr - `IO_BASE) < `IO_SPAN) begin
            return proc_bus_pkg::REGION_IO;
        end
        return proc_bus_pkg::REGION_NONE;
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input proc_bus_pkg::addr_t addr);
        proc_bus_pkg::addr_t offset;
        offset = addr - `SRAM_BASE;
        return offset[IDX_W+1:2];
    endfunction

    function automatic proc_bus_pkg::word_t merge_bytes(input proc_bus_pkg::word_t old_word,
                                                        input proc_bus_pkg::word_t new_word,
                                                        input proc_bus_pkg::strb_t strb);
        proc_bus_pkg::word_t w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic note_write(input proc_bus_pkg::addr_t addr, input proc_bus_pkg::word_t data,
                              input proc_bus_pkg::strb_t strb);
        logic [IDX_W-1:0] idx;
        idx = word_index(addr);
        if (region_of(addr) == proc_bus_pkg::REGION_SRAM && (ref_valid[idx] || strb == 4'hF)) begin
            ref_mem[idx]   = merge_bytes(ref_mem[idx], data, strb);
            ref_valid[idx] = 1'b1;
        end
    endtask

    // One core access, held until the response pulse
    task automatic bus_access(input logic is_write, input proc_bus_pkg::addr_t addr,
                              input proc_bus_pkg::word_t data, input proc_bus_pkg::strb_t strb,
                              output proc_bus_pkg::word_t rdata);
        int   cycles;
        logic seen;
        cycles     = 0;
        seen       = 1'b0;
        mem_read   = !is_write;
        mem_write  = is_write;
        address    = addr;
        write_data = data;
        wstrb      = strb;
        while (!seen && cycles < RESP_TIMEOUT) begin
            @(posedge sys_clk);
            #1;
            cycles++;
            seen = mem_response;
        end
        mem_read  = 1'b0;   // Dropped inside the response cycle
        mem_write = 1'b0;
        rdata     = read_data;
        if (!seen) begin
            errors++;
            $display("No response within %0d cycles to the access at %08h", RESP_TIMEOUT, addr);
        end else begin
            @(posedge sys_clk);
            #1;
            compare_bit("mem_response_o", 1'b0, mem_response);   // Exactly one pulse
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        do begin
            @(posedge sys_clk);
            #1;
            cycles++;
        end while (rst && cycles < RESET_TIMEOUT);
        if (rst) begin
            errors++;
            $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
        end
    endtask

    task automatic check_idle();
        int errors_before;
        errors_before = errors;
        repeat (8) begin
            compare_bit("mem_response_o", 1'b0, mem_response);
            compare_gpio("gpio_o", 8'h00, gpio);
            @(posedge sys_clk);
            #1;
        end
        finish_test("idle after reset", errors_before);
    endtask

    task automatic run_cases();
        int                  line;
        int                  base;
        int                  errors_before;
        proc_bus_pkg::word_t op;
        proc_bus_pkg::word_t addr;
        proc_bus_pkg::word_t data;
        proc_bus_pkg::word_t strb;
        proc_bus_pkg::word_t expected;
        proc_bus_pkg::word_t rdata;
        line          = 0;
        errors_before = errors;
        op            = cases[0];
        while (op != OP_END && line < MAX_LINES) begin
            base     = line * 5;
            addr     = cases[8'(base + 1)];
            data     = cases[8'(base + 2)];
            strb     = cases[8'(base + 3)];
            expected = cases[8'(base + 4)];
            case (op)
                OP_WRITE: begin
                    bus_access(1'b1, addr, data, strb[3:0], rdata);
                    note_write(addr, data, strb[3:0]);
                end
                OP_READ: begin
                    bus_access(1'b0, addr, '0, '0, rdata);
                    compare_word("read_data_o", expected, rdata);
                    if (region_of(addr) == proc_bus_pkg::REGION_NONE) begin
                        compare_word("read_data_o unmapped", `UNMAPPED_DATA, rdata);
                    end
                end
                OP_GPIO: compare_gpio("gpio_o", expected[7:0], gpio);
                OP_MARK: begin
                    finish_test($sformatf("directed group %0d", data), errors_before);
                    errors_before = errors;
                end
                default: begin
                    errors++;
                    $display("Unknown opcode %0h on case line %0d", op, line);
                end
            endcase
            line++;
            op = cases[8'(line * 5)];
        end
    endtask

    task automatic run_random();
        logic [31:0]         rng;
        logic [IDX_W-1:0]    idx;
        proc_bus_pkg::addr_t addr;
        proc_bus_pkg::word_t data;
        proc_bus_pkg::strb_t strb;
        proc_bus_pkg::word_t rdata;
        int                  errors_before;
        errors_before = errors;
        rng           = 32'h68f9;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rng  = xorshift32(rng);
            idx  = rng[8 +: IDX_W];
            addr = `SRAM_BASE + 32'({idx, 2'b00});
            if (rng[0] || !ref_valid[idx]) begin
                strb = ref_valid[idx] ? rng[7:4] : 4'hF;   // Unknown words get a full write
                rng  = xorshift32(rng);
                data = rng;
                bus_access(1'b1, addr, data, strb, rdata);
                note_write(addr, data, strb);
            end else begin
                bus_access(1'b0, addr, '0, '0, rdata);
                compare_word("read_data_o", ref_mem[idx], rdata);
            end
        end
        finish_test("random SRAM traffic", errors_before);
    endtask

    initial begin
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        address      = '0;
        write_data   = '0;
        wstrb        = '0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        foreach (ref_valid[i]) begin
            ref_valid[i] = 1'b0;
        end
        foreach (cases[i]) begin
            cases[i] = '0;   // Unused slots read as end of file
        end
        $readmemh("verif/bus_cases.txt", cases);

        wait_reset_release();
        check_idle();
        run_cases();
        run_random();

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/bus_cases.txt
// op address data strobes expected, all hex
// op 1 write, 2 read and check, 3 check gpio_o, 4 end of group (data = group), 0 end
1 00000010 CAFEF00D F 00000000
2 00000010 00000000 0 CAFEF00D
1 000003FC 01234567 F 00000000
2 000003FC 00000000 0 01234567
4 00000000 00000002 0 00000000
1 00000020 11223344 F 00000000
1 00000020 AABBCCDD 5 00000000
2 00000020 00000000 0 11BB33DD
1 00000020 99887766 8 00000000
2 00000020 00000000 0 99BB33DD
4 00000000 00000003 0 00000000
1 10000000 000000A5 1 00000000
3 00000000 00000000 0 000000A5
2 10000000 00000000 0 000000A5
1 10000000 0000005A E 00000000
3 00000000 00000000 0 000000A5
1 10000004 DEADC0DE F 00000000
2 10000004 00000000 0 DEADC0DE
4 00000000 00000004 0 00000000
2 20000040 00000000 0 DEADBEEF
1 20000010 FFFFFFFF F 00000000
1 10000104 FFFFFFFF F 00000000
2 00000010 00000000 0 CAFEF00D
2 10000004 00000000 0 DEADC0DE
3 00000000 00000000 0 000000A5
4 00000000 00000005 0 00000000
0 00000000 00000000 0 00000000

//--- vlog.f
+incdir+src
src/proc_bus_pkg.sv
src/core_bus_master.sv
src/wb_addr_decoder.sv
src/wb_sram.sv
src/wb_io_regs.sv
src/proc_mem_top.sv
verif/tb_clock_gen.sv
verif/tb_proc_mem_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_proc_mem_top
FILELIST  := vlog.f
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP)
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS

SRCS := $(shell grep -v '^+' $(FILELIST)) src/proc_bus_consts.svh verif/bus_cases.txt

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
